/* Makefile */
SIM      ?= verilator
TOP      ?= tb_or1k_decode_stage
FILELIST ?= or1k_decode_stage.f
FLAGS    ?= --binary --timing --assert -j 0
OBJ_DIR  ?= obj_dir
PASS_MSG := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with $(SIM) and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* hdl/decode_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface decode_if;
  import or1k_decode_pkg::*;

  logic                     vld;
  decode_ops_t              ops;
  logic [OPERAND_WIDTH-1:0] imm;
  logic                     imm_sel;

  modport producer (
    output vld,
    output ops,
    output imm,
    output imm_sel
  );

  modport consumer (
    input vld,
    input ops,
    input imm,
    input imm_sel
  );

endinterface

`default_nettype wire

/* hdl/decode_out_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_out_reg (
  input  logic                                      clk,
  input  logic                                      arst_n_i,
  decode_if.consumer                                dec,
  output or1k_decode_pkg::decode_ops_t              ops_o,
  output logic [or1k_decode_pkg::OPERAND_WIDTH-1:0] imm_o,
  output logic                                      imm_sel_o,
  output logic                                      valid_o
);
  import or1k_decode_pkg::*;

  decode_ops_t ops_q;
  logic [2:0]  exc_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
      exc_q   <= '0;
    end else begin
      valid_o <= dec.vld;
      if (dec.vld) begin
        exc_q <= {dec.ops.except_illegal, dec.ops.except_syscall, dec.ops.except_trap};
      end
    end
  end

  // Results hold between accepted instructions
  always_ff @(posedge clk) begin
    if (dec.vld) begin
      ops_q     <= dec.ops;
      imm_o     <= dec.imm;
      imm_sel_o <= dec.imm_sel;
    end
  end

  always_comb begin
    ops_o                = ops_q;
    ops_o.except_illegal = exc_q[2];
    ops_o.except_syscall = exc_q[1];
    ops_o.except_trap    = exc_q[0];
  end

  // A loaded result never carries unknown bits
  a_loaded_known: assert property (
    @(posedge clk) disable iff (!arst_n_i)
      dec.vld |-> !$isunknown({dec.ops, dec.imm, dec.imm_sel})
  );

endmodule

`default_nettype wire

/* hdl/illegal_check.sv */
`timescale 1ns/1ns
`default_nettype none

module illegal_check (
  input  logic [or1k_decode_pkg::INSN_WIDTH-1:0] insn_i,
  output logic                                   illegal_o,
  output logic                                   syscall_o,
  output logic                                   trap_o
);
  import or1k_decode_pkg::*;

  opcode_e    opc;
  alu_opc_e   alu_opc;
  shift_opc_e shift_opc;
  sys_opc_e   sys_opc;
  logic       shift_illegal;

  assign opc       = opcode_e'(insn_i[OPCODE_LSB +: OPCODE_WIDTH]);
  assign alu_opc   = alu_opc_e'(insn_i[ALU_OPC_LSB +: ALU_OPC_WIDTH]);
  assign shift_opc = shift_opc_e'(insn_i[SHIFT_OPC_LSB +: SHIFT_OPC_WIDTH]);
  assign sys_opc   = sys_opc_e'(insn_i[SYS_OPC_LSB +: SYS_OPC_WIDTH]);

  assign syscall_o = (opc == OPC_SYSTRAPSYNC) && (sys_opc == SYS_SYSCALL);
  assign trap_o    = (opc == OPC_SYSTRAPSYNC) && (sys_opc == SYS_TRAP);

  // Shared by shrti and the ALU shift form
  always_comb begin
    case (shift_opc)
      SHIFT_SLL, SHIFT_SRL: shift_illegal = 1'b0;
      SHIFT_SRA:            shift_illegal = !HAS_SRA;
      default:              shift_illegal = !HAS_ROR;
    endcase
  end

  always_comb begin
    illegal_o = 1'b1;
    case (opc)
      OPC_J, OPC_JAL, OPC_BNF, OPC_BF, OPC_NOP, OPC_MOVHI, OPC_RFE, OPC_JR, OPC_JALR,
      OPC_LWZ, OPC_LWS, OPC_LBZ, OPC_LBS, OPC_LHZ, OPC_LHS,
      OPC_ADDI, OPC_ANDI, OPC_ORI, OPC_XORI, OPC_MFSPR, OPC_SFIMM,
      OPC_MTSPR, OPC_SW, OPC_SB, OPC_SH, OPC_SF:
        illegal_o = 1'b0;
      OPC_LWA, OPC_SWA: illegal_o = !HAS_ATOMIC;
      OPC_MULI:         illegal_o = !HAS_MULTIPLIER;
      OPC_SHRTI:        illegal_o = shift_illegal;
      OPC_ALU: begin
        case (alu_opc)
          ALU_ADD, ALU_SUB, ALU_OR, ALU_XOR, ALU_AND: illegal_o = 1'b0;
          ALU_MUL, ALU_MULU: illegal_o = !HAS_MULTIPLIER;
          ALU_DIV, ALU_DIVU: illegal_o = !HAS_DIVIDER;
          ALU_SHRT:          illegal_o = shift_illegal;
          default:           illegal_o = 1'b1;
        endcase
      end
      OPC_SYSTRAPSYNC: begin
        case (sys_opc)
          SYS_SYSCALL: illegal_o = !HAS_SYSCALL;
          SYS_TRAP:    illegal_o = !HAS_TRAP;
          SYS_MSYNC:   illegal_o = !HAS_MSYNC;
          default:     illegal_o = 1'b1;
        endcase
      end
      default: illegal_o = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/immediate_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module immediate_gen (
  input  logic [or1k_decode_pkg::INSN_WIDTH-1:0]    insn_i,
  output logic [or1k_decode_pkg::OPERAND_WIDTH-1:0] imm_o,
  output logic                                      imm_sel_o
);
  import or1k_decode_pkg::*;

  opcode_e              opc;
  logic                 is_store;
  logic [IMM_WIDTH-1:0] imm16;
  logic                 sext_sel;
  logic                 zext_sel;
  logic                 high_sel;

  assign opc      = opcode_e'(insn_i[OPCODE_LSB +: OPCODE_WIDTH]);
  assign is_store = (opc == OPC_SW) || (opc == OPC_SB) || (opc == OPC_SH);

  // Stores and mtspr keep rD free, so the immediate is split around it
  assign imm16 = (is_store || (opc == OPC_MTSPR)) ?
                 {insn_i[RD_LSB +: RF_ADDR_WIDTH], insn_i[SPLIT_IMM_LO_WIDTH-1:0]} :
                 insn_i[IMM_LSB +: IMM_WIDTH];

  assign sext_sel = ((insn_i[INSN_WIDTH-1 -: 2] == 2'b10) &&
                     (opc != OPC_ORI) && (opc != OPC_ANDI)) || is_store;
  assign zext_sel = (opc == OPC_ORI) || (opc == OPC_ANDI) || (opc == OPC_MTSPR);
  assign high_sel = opc == OPC_MOVHI;

  always_comb begin
    if (sext_sel) begin
      imm_o = {{(OPERAND_WIDTH-IMM_WIDTH){imm16[IMM_WIDTH-1]}}, imm16};
    end else if (zext_sel) begin
      imm_o = {{(OPERAND_WIDTH-IMM_WIDTH){1'b0}}, imm16};
    end else begin
      imm_o = {imm16, {(OPERAND_WIDTH-IMM_WIDTH){1'b0}}};
    end
  end

  assign imm_sel_o = sext_sel || zext_sel || high_sel;

endmodule

`default_nettype wire

/* hdl/insn_capture.sv */
`timescale 1ns/1ns
`default_nettype none

module insn_capture (
  input  logic                                   clk,
  input  logic                                   arst_n_i,
  input  logic                                   insn_valid_i,
  input  logic [or1k_decode_pkg::INSN_WIDTH-1:0] insn_i,
  output logic [or1k_decode_pkg::INSN_WIDTH-1:0] insn_o,
  output logic                                   insn_vld_o
);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      insn_vld_o <= 1'b0;
    end else begin
      insn_vld_o <= insn_valid_i;
    end
  end

  // Instruction word only moves on a strobe
  always_ff @(posedge clk) begin
    if (insn_valid_i) begin
      insn_o <= insn_i;
    end
  end

  a_valid_known: assert property (
    @(posedge clk) disable iff (!arst_n_i) !$isunknown(insn_valid_i)
  );

endmodule

`default_nettype wire

/* hdl/opcode_classifier.sv */
`timescale 1ns/1ns
`default_nettype none

module opcode_classifier (
  input  logic [or1k_decode_pkg::INSN_WIDTH-1:0] insn_i,
  output or1k_decode_pkg::decode_ops_t           ops_o
);
  import or1k_decode_pkg::*;

  opcode_e  opc;
  alu_opc_e alu_opc;

  assign opc     = opcode_e'(insn_i[OPCODE_LSB +: OPCODE_WIDTH]);
  assign alu_opc = alu_opc_e'(insn_i[ALU_OPC_LSB +: ALU_OPC_WIDTH]);

  always_comb begin
    // Exception fields are filled in by illegal_check
    ops_o = '0;

    // Loads sit at 0x21..0x26
    ops_o.op_lsu_load  = (opc >= OPC_LWZ) && (opc <= OPC_LHS);
    ops_o.op_lsu_store = (opc == OPC_SW) || (opc == OPC_SB) || (opc == OPC_SH);

    case (opc)
      OPC_SB, OPC_LBZ, OPC_LBS: ops_o.lsu_length = LSU_BYTE;
      OPC_SH, OPC_LHZ, OPC_LHS: ops_o.lsu_length = LSU_HALF;
      default:                  ops_o.lsu_length = LSU_WORD;
    endcase
    ops_o.lsu_zext = insn_i[OPCODE_LSB];

    // Everything below l.nop branches against an immediate
    ops_o.op_jbr = opc < OPC_NOP;
    ops_o.op_jr  = (opc == OPC_JR) || (opc == OPC_JALR);
    ops_o.op_jal = (opc == OPC_JAL) || (opc == OPC_JALR);
    ops_o.op_bf  = opc == OPC_BF;
    ops_o.op_bnf = opc == OPC_BNF;

    ops_o.op_alu = (opc == OPC_ALU) || (opc == OPC_ORI) ||
                   (opc == OPC_ANDI) || (opc == OPC_XORI);
    ops_o.op_mfspr   = opc == OPC_MFSPR;
    ops_o.op_mtspr   = opc == OPC_MTSPR;
    ops_o.op_rfe     = opc == OPC_RFE;
    ops_o.op_movhi   = opc == OPC_MOVHI;
    ops_o.op_setflag = (opc == OPC_SF) || (opc == OPC_SFIMM);
    ops_o.op_add     = ((opc == OPC_ALU) && ((alu_opc == ALU_ADD) || (alu_opc == ALU_SUB))) ||
                       (opc == OPC_ADDI);
    ops_o.op_mul     = ((opc == OPC_ALU) && ((alu_opc == ALU_MUL) || (alu_opc == ALU_MULU))) ||
                       (opc == OPC_MULI);
    ops_o.op_shift   = ((opc == OPC_ALU) && (alu_opc == ALU_SHRT)) || (opc == OPC_SHRTI);
    ops_o.op_msync   = HAS_MSYNC && (opc == OPC_SYSTRAPSYNC) &&
                       (insn_i[SYS_OPC_LSB +: SYS_OPC_WIDTH] == SYS_MSYNC);

    // Immediate logic ops reuse the register ALU codes
    case (opc)
      OPC_ORI:  ops_o.opc_alu = ALU_OR;
      OPC_ANDI: ops_o.opc_alu = ALU_AND;
      OPC_XORI: ops_o.opc_alu = ALU_XOR;
      default:  ops_o.opc_alu = alu_opc;
    endcase
    ops_o.opc_alu_secondary = ops_o.op_setflag ? insn_i[COMP_OPC_LSB +: COMP_OPC_WIDTH] :
                              {{(ALU_OPC_WIDTH-SHIFT_OPC_WIDTH){1'b0}},
                               insn_i[SHIFT_OPC_LSB +: SHIFT_OPC_WIDTH]};

    // Compares go through the subtractor
    ops_o.adder_do_sub = ((opc == OPC_ALU) && (alu_opc == ALU_SUB)) || ops_o.op_setflag;

    ops_o.rfa_adr = insn_i[RA_LSB +: RF_ADDR_WIDTH];
    ops_o.rfb_adr = insn_i[RB_LSB +: RF_ADDR_WIDTH];
    ops_o.rfd_adr = ops_o.op_jal ? LINK_REG : insn_i[RD_LSB +: RF_ADDR_WIDTH];

    // 10xxxx except sfimm, 11xxxx except sf, mtspr and stores
    ops_o.rf_wb = (opc == OPC_JAL) || (opc == OPC_JALR) || (opc == OPC_MOVHI) ||
                  ((insn_i[INSN_WIDTH-1 -: 2] == 2'b10) && (opc != OPC_SFIMM)) ||
                  ((insn_i[INSN_WIDTH-1 -: 2] == 2'b11) &&
                   !((opc == OPC_SF) || ops_o.op_mtspr || ops_o.op_lsu_store));
  end

endmodule

`default_nettype wire

/* hdl/or1k_decode_pkg.sv */
`default_nettype none

package or1k_decode_pkg;

  localparam int INSN_WIDTH    = 32;
  localparam int OPERAND_WIDTH = 32;
  localparam int RF_ADDR_WIDTH = 5;
  localparam int IMM_WIDTH     = 16;

  localparam int OPCODE_WIDTH    = 6;
  localparam int ALU_OPC_WIDTH   = 4;
  localparam int SHIFT_OPC_WIDTH = 2;
  localparam int COMP_OPC_WIDTH  = 4;
  localparam int SYS_OPC_WIDTH   = 5;

  // LSB of each instruction field
  localparam int OPCODE_LSB    = 26;
  localparam int RD_LSB        = 21;
  localparam int RA_LSB        = 16;
  localparam int RB_LSB        = 11;
  localparam int IMM_LSB       = 0;
  localparam int ALU_OPC_LSB   = 0;
  localparam int SHIFT_OPC_LSB = 6;
  localparam int COMP_OPC_LSB  = 21;
  localparam int SYS_OPC_LSB   = 21;

  // Low part of the split store/mtspr immediate
  localparam int SPLIT_IMM_LO_WIDTH = 11;

  localparam logic [RF_ADDR_WIDTH-1:0] LINK_REG = 5'd9;

  // Fixed feature set of this core
  localparam bit HAS_MULTIPLIER = 1'b1;
  localparam bit HAS_DIVIDER    = 1'b0;
  localparam bit HAS_SRA        = 1'b1;
  localparam bit HAS_ROR        = 1'b0;
  localparam bit HAS_SYSCALL    = 1'b1;
  localparam bit HAS_TRAP       = 1'b1;
  localparam bit HAS_MSYNC      = 1'b1;
  localparam bit HAS_ATOMIC     = 1'b0;

  typedef enum logic [OPCODE_WIDTH-1:0] {
    OPC_J           = 6'h00,
    OPC_JAL         = 6'h01,
    OPC_BNF         = 6'h03,
    OPC_BF          = 6'h04,
    OPC_NOP         = 6'h05,
    OPC_MOVHI       = 6'h06,
    OPC_SYSTRAPSYNC = 6'h08,
    OPC_RFE         = 6'h09,
    OPC_JR          = 6'h11,
    OPC_JALR        = 6'h12,
    OPC_LWA         = 6'h1b,
    OPC_LWZ         = 6'h21,
    OPC_LWS         = 6'h22,
    OPC_LBZ         = 6'h23,
    OPC_LBS         = 6'h24,
    OPC_LHZ         = 6'h25,
    OPC_LHS         = 6'h26,
    OPC_ADDI        = 6'h27,
    OPC_ANDI        = 6'h29,
    OPC_ORI         = 6'h2a,
    OPC_XORI        = 6'h2b,
    OPC_MULI        = 6'h2c,
    OPC_MFSPR       = 6'h2d,
    OPC_SHRTI       = 6'h2e,
    OPC_SFIMM       = 6'h2f,
    OPC_MTSPR       = 6'h30,
    OPC_SWA         = 6'h33,
    OPC_SW          = 6'h35,
    OPC_SB          = 6'h36,
    OPC_SH          = 6'h37,
    OPC_ALU         = 6'h38,
    OPC_SF          = 6'h39
  } opcode_e;

  typedef enum logic [ALU_OPC_WIDTH-1:0] {
    ALU_ADD   = 4'h0,
    ALU_ADDC  = 4'h1,
    ALU_SUB   = 4'h2,
    ALU_AND   = 4'h3,
    ALU_OR    = 4'h4,
    ALU_XOR   = 4'h5,
    ALU_MUL   = 4'h6,
    ALU_RESV  = 4'h7,
    ALU_SHRT  = 4'h8,
    ALU_DIV   = 4'h9,
    ALU_DIVU  = 4'ha,
    ALU_MULU  = 4'hb,
    ALU_EXTBH = 4'hc,
    ALU_EXTW  = 4'hd,
    ALU_CMOV  = 4'he,
    ALU_FFL1  = 4'hf
  } alu_opc_e;

  typedef enum logic [SHIFT_OPC_WIDTH-1:0] {
    SHIFT_SLL = 2'h0,
    SHIFT_SRL = 2'h1,
    SHIFT_SRA = 2'h2,
    SHIFT_ROR = 2'h3
  } shift_opc_e;

  typedef enum logic [SYS_OPC_WIDTH-1:0] {
    SYS_SYSCALL = 5'b00000,
    SYS_TRAP    = 5'b01000,
    SYS_MSYNC   = 5'b10000,
    SYS_PSYNC   = 5'b10100,
    SYS_CSYNC   = 5'b11000
  } sys_opc_e;

  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_len_e;

  typedef struct packed {
    logic                     op_jbr;
    logic                     op_jr;
    logic                     op_jal;
    logic                     op_bf;
    logic                     op_bnf;
    logic                     op_alu;
    logic                     op_lsu_load;
    logic                     op_lsu_store;
    lsu_len_e                 lsu_length;
    logic                     lsu_zext;
    logic                     op_mfspr;
    logic                     op_mtspr;
    logic                     op_rfe;
    logic                     op_setflag;
    logic                     op_add;
    logic                     op_mul;
    logic                     op_shift;
    logic                     op_movhi;
    logic                     op_msync;
    alu_opc_e                 opc_alu;
    logic [ALU_OPC_WIDTH-1:0] opc_alu_secondary;
    logic [RF_ADDR_WIDTH-1:0] rfd_adr;
    logic [RF_ADDR_WIDTH-1:0] rfa_adr;
    logic [RF_ADDR_WIDTH-1:0] rfb_adr;
    logic                     rf_wb;
    logic                     adder_do_sub;
    logic                     except_illegal;
    logic                     except_syscall;
    logic                     except_trap;
  } decode_ops_t;

endpackage

`default_nettype wire

/* hdl/or1k_decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module or1k_decode_stage (
  input  logic                                       clk,
  input  logic                                       arst_n_i,
  input  logic                                       insn_valid_i,
  input  logic [or1k_decode_pkg::INSN_WIDTH-1:0]     insn_i,
  output logic                                       valid_o,
  output logic [or1k_decode_pkg::ALU_OPC_WIDTH-1:0]  opc_alu_o,
  output logic [or1k_decode_pkg::ALU_OPC_WIDTH-1:0]  opc_alu_secondary_o,
  output logic [or1k_decode_pkg::OPERAND_WIDTH-1:0]  immediate_o,
  output logic                                       immediate_sel_o,
  output logic [or1k_decode_pkg::RF_ADDR_WIDTH-1:0]  rfd_adr_o,
  output logic [or1k_decode_pkg::RF_ADDR_WIDTH-1:0]  rfa_adr_o,
  output logic [or1k_decode_pkg::RF_ADDR_WIDTH-1:0]  rfb_adr_o,
  output logic                                       rf_wb_o,
  output logic                                       op_jbr_o,
  output logic                                       op_jr_o,
  output logic                                       op_jal_o,
  output logic                                       op_bf_o,
  output logic                                       op_bnf_o,
  output logic                                       op_alu_o,
  output logic                                       op_lsu_load_o,
  output logic                                       op_lsu_store_o,
  output logic [1:0]                                 lsu_length_o,
  output logic                                       lsu_zext_o,
  output logic                                       op_mfspr_o,
  output logic                                       op_mtspr_o,
  output logic                                       op_rfe_o,
  output logic                                       op_setflag_o,
  output logic                                       op_add_o,
  output logic                                       op_mul_o,
  output logic                                       op_shift_o,
  output logic                                       op_movhi_o,
  output logic                                       op_msync_o,
  output logic                                       adder_do_sub_o,
  output logic                                       except_illegal_o,
  output logic                                       except_syscall_o,
  output logic                                       except_trap_o
);
  import or1k_decode_pkg::*;

  logic [INSN_WIDTH-1:0] insn_q;
  logic                  insn_vld_q;
  decode_ops_t           cls_ops;
  decode_ops_t           ops_q;
  logic                  illegal;
  logic                  syscall;
  logic                  trap;

  decode_if dec ();

  insn_capture u_capture (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .insn_valid_i (insn_valid_i),
    .insn_i       (insn_i),
    .insn_o       (insn_q),
    .insn_vld_o   (insn_vld_q)
  );

  opcode_classifier u_classifier (
    .insn_i (insn_q),
    .ops_o  (cls_ops)
  );

  immediate_gen u_imm (
    .insn_i    (insn_q),
    .imm_o     (dec.imm),
    .imm_sel_o (dec.imm_sel)
  );

  illegal_check u_illegal (
    .insn_i    (insn_q),
    .illegal_o (illegal),
    .syscall_o (syscall),
    .trap_o    (trap)
  );

  assign dec.vld = insn_vld_q;

  // Merge exception flags into the classifier result
  always_comb begin
    dec.ops                = cls_ops;
    dec.ops.except_illegal = illegal;
    dec.ops.except_syscall = syscall;
    dec.ops.except_trap    = trap;
  end

  decode_out_reg u_out (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .dec       (dec.consumer),
    .ops_o     (ops_q),
    .imm_o     (immediate_o),
    .imm_sel_o (immediate_sel_o),
    .valid_o   (valid_o)
  );

  assign opc_alu_o           = ops_q.opc_alu;
  assign opc_alu_secondary_o = ops_q.opc_alu_secondary;
  assign rfd_adr_o           = ops_q.rfd_adr;
  assign rfa_adr_o           = ops_q.rfa_adr;
  assign rfb_adr_o           = ops_q.rfb_adr;
  assign rf_wb_o             = ops_q.rf_wb;
  assign op_jbr_o            = ops_q.op_jbr;
  assign op_jr_o             = ops_q.op_jr;
  assign op_jal_o            = ops_q.op_jal;
  assign op_bf_o             = ops_q.op_bf;
  assign op_bnf_o            = ops_q.op_bnf;
  assign op_alu_o            = ops_q.op_alu;
  assign op_lsu_load_o       = ops_q.op_lsu_load;
  assign op_lsu_store_o      = ops_q.op_lsu_store;
  assign lsu_length_o        = ops_q.lsu_length;
  assign lsu_zext_o          = ops_q.lsu_zext;
  assign op_mfspr_o          = ops_q.op_mfspr;
  assign op_mtspr_o          = ops_q.op_mtspr;
  assign op_rfe_o            = ops_q.op_rfe;
  assign op_setflag_o        = ops_q.op_setflag;
  assign op_add_o            = ops_q.op_add;
  assign op_mul_o            = ops_q.op_mul;
  assign op_shift_o          = ops_q.op_shift;
  assign op_movhi_o          = ops_q.op_movhi;
  assign op_msync_o          = ops_q.op_msync;
  assign adder_do_sub_o      = ops_q.adder_do_sub;
  assign except_illegal_o    = ops_q.except_illegal;
  assign except_syscall_o    = ops_q.except_syscall;
  assign except_trap_o       = ops_q.except_trap;

endmodule

`default_nettype wire

/* or1k_decode_stage.f */
+incdir+verif
hdl/or1k_decode_pkg.sv
hdl/decode_if.sv
hdl/insn_capture.sv
hdl/opcode_classifier.sv
hdl/immediate_gen.sv
hdl/illegal_check.sv
hdl/decode_out_reg.sv
hdl/or1k_decode_stage.sv
verif/tb_or1k_decode_stage.sv

/* verif/decode_ref_model.svh */
`ifndef DECODE_REF_MODEL_SVH
`define DECODE_REF_MODEL_SVH

// Expected values of every DUT output for one instruction
typedef struct packed {
  logic [3:0]  opc_alu;
  logic [3:0]  opc_alu_sec;
  logic [31:0] imm;
  logic        imm_sel;
  logic [4:0]  rfd;
  logic [4:0]  rfa;
  logic [4:0]  rfb;
  logic        rf_wb;
  logic        jbr;
  logic        jr;
  logic        jal;
  logic        bf;
  logic        bnf;
  logic        alu;
  logic        load;
  logic        store;
  logic [1:0]  lsu_len;
  logic        zext;
  logic        mfspr;
  logic        mtspr;
  logic        rfe;
  logic        setflag;
  logic        add;
  logic        mul;
  logic        shift;
  logic        movhi;
  logic        msync;
  logic        sub;
  logic        illegal;
  logic        syscall;
  logic        trap;
} dec_exp_t;

// Legal list of the fixed feature set
function automatic logic legal_insn(input logic [31:0] w);
  logic [5:0] opc;
  logic [3:0] alu;
  logic       shift_ok;
  opc = w[31:26];
  alu = w[3:0];
  // ROR is absent
  shift_ok = w[7:6] != 2'd3;
  case (opc)
    6'h00, 6'h01, 6'h03, 6'h04, 6'h05, 6'h06, 6'h09, 6'h11, 6'h12:
      return 1'b1;
    6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h29, 6'h2a, 6'h2b,
    6'h2c, 6'h2d, 6'h2f, 6'h30, 6'h35, 6'h36, 6'h37, 6'h39:
      return 1'b1;
    6'h2e:
      return shift_ok;
    6'h38:
      return (alu inside {4'h0, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'hb}) ||
             ((alu == 4'h8) && shift_ok);
    6'h08:
      return w[25:21] inside {5'h00, 5'h08, 5'h10};
    default:
      return 1'b0;
  endcase
endfunction

function automatic dec_exp_t model_decode(input logic [31:0] w);
  dec_exp_t    e;
  logic [5:0]  opc;
  logic [3:0]  alu;
  logic [15:0] imm16;
  opc = w[31:26];
  alu = w[3:0];
  e = '0;
  e.load  = (opc >= 6'h21) && (opc <= 6'h26);
  e.store = opc inside {6'h35, 6'h36, 6'h37};
  if (opc inside {6'h36, 6'h23, 6'h24}) begin
    e.lsu_len = 2'b00;
  end else if (opc inside {6'h37, 6'h25, 6'h26}) begin
    e.lsu_len = 2'b01;
  end else begin
    e.lsu_len = 2'b10;
  end
  e.zext    = w[26];
  e.jbr     = opc < 6'h05;
  e.jr      = opc inside {6'h11, 6'h12};
  e.jal     = opc inside {6'h01, 6'h12};
  e.bf      = opc == 6'h04;
  e.bnf     = opc == 6'h03;
  e.alu     = opc inside {6'h38, 6'h29, 6'h2a, 6'h2b};
  e.mfspr   = opc == 6'h2d;
  e.mtspr   = opc == 6'h30;
  e.rfe     = opc == 6'h09;
  e.movhi   = opc == 6'h06;
  e.setflag = opc inside {6'h39, 6'h2f};
  e.add     = ((opc == 6'h38) && (alu inside {4'h0, 4'h2})) || (opc == 6'h27);
  e.mul     = ((opc == 6'h38) && (alu inside {4'h6, 4'hb})) || (opc == 6'h2c);
  e.shift   = ((opc == 6'h38) && (alu == 4'h8)) || (opc == 6'h2e);
  e.msync   = (opc == 6'h08) && (w[25:21] == 5'h10);
  case (opc)
    6'h2a:   e.opc_alu = 4'h4;
    6'h29:   e.opc_alu = 4'h3;
    6'h2b:   e.opc_alu = 4'h5;
    default: e.opc_alu = alu;
  endcase
  e.opc_alu_sec = e.setflag ? w[24:21] : {2'b00, w[7:6]};
  e.sub = ((opc == 6'h38) && (alu == 4'h2)) || e.setflag;
  e.rfa = w[20:16];
  e.rfb = w[15:11];
  e.rfd = e.jal ? 5'd9 : w[25:21];
  e.rf_wb = (opc inside {6'h01, 6'h12, 6'h06}) ||
            ((opc[5:4] == 2'b10) && (opc != 6'h2f)) ||
            ((opc[5:4] == 2'b11) && !(opc inside {6'h39, 6'h30, 6'h35, 6'h36, 6'h37}));
  // Split form for stores and mtspr
  imm16 = (e.store || (opc == 6'h30)) ? {w[25:21], w[10:0]} : w[15:0];
  if (((opc[5:4] == 2'b10) && !(opc inside {6'h2a, 6'h29})) || e.store) begin
    e.imm     = {{16{imm16[15]}}, imm16};
    e.imm_sel = 1'b1;
  end else if (opc inside {6'h2a, 6'h29, 6'h30}) begin
    e.imm     = {16'h0000, imm16};
    e.imm_sel = 1'b1;
  end else if (opc == 6'h06) begin
    e.imm     = {imm16, 16'h0000};
    e.imm_sel = 1'b1;
  end
  e.illegal = !legal_insn(w);
  e.syscall = (opc == 6'h08) && (w[25:21] == 5'h00);
  e.trap    = (opc == 6'h08) && (w[25:21] == 5'h08);
  return e;
endfunction

`endif

/* verif/tb_or1k_decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_or1k_decode_stage;

  `include "decode_ref_model.svh"

  localparam int DRAIN_LIMIT = 64;

  localparam logic [5:0] LEGAL_OPCS [30] = '{
    6'h00, 6'h01, 6'h03, 6'h04, 6'h05, 6'h06, 6'h08, 6'h09, 6'h11, 6'h12,
    6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h29, 6'h2a, 6'h2b,
    6'h2c, 6'h2d, 6'h2e, 6'h2f, 6'h30, 6'h35, 6'h36, 6'h37, 6'h38, 6'h39
  };
  localparam logic [3:0] ALU_OK [8] = '{4'h0, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'hb, 4'h8};
  localparam logic [4:0] SYS_OK [3] = '{5'h00, 5'h08, 5'h10};
  localparam logic [4:0] SYS_ALL [5] = '{5'h00, 5'h08, 5'h10, 5'h14, 5'h18};
  localparam logic [5:0] IMM_OPCS [13] = '{
    6'h27, 6'h2a, 6'h29, 6'h06, 6'h35, 6'h36, 6'h37, 6'h30,
    6'h21, 6'h22, 6'h23, 6'h24, 6'h25
  };

  logic        clk;
  logic        arst_n_i;
  logic        insn_valid_i;
  logic [31:0] insn_i;
  logic        valid_o;
  logic [3:0]  opc_alu_o;
  logic [3:0]  opc_alu_secondary_o;
  logic [31:0] immediate_o;
  logic        immediate_sel_o;
  logic [4:0]  rfd_adr_o;
  logic [4:0]  rfa_adr_o;
  logic [4:0]  rfb_adr_o;
  logic        rf_wb_o;
  logic        op_jbr_o;
  logic        op_jr_o;
  logic        op_jal_o;
  logic        op_bf_o;
  logic        op_bnf_o;
  logic        op_alu_o;
  logic        op_lsu_load_o;
  logic        op_lsu_store_o;
  logic [1:0]  lsu_length_o;
  logic        lsu_zext_o;
  logic        op_mfspr_o;
  logic        op_mtspr_o;
  logic        op_rfe_o;
  logic        op_setflag_o;
  logic        op_add_o;
  logic        op_mul_o;
  logic        op_shift_o;
  logic        op_movhi_o;
  logic        op_msync_o;
  logic        adder_do_sub_o;
  logic        except_illegal_o;
  logic        except_syscall_o;
  logic        except_trap_o;

  dec_exp_t exp_q [$];
  int       due_q [$];
  int       due;
  int       cyc;
  int       errors;
  int       checks;
  int       accepted;
  int       results;
  int       err_start;
  int       acc_start;
  int       res_start;
  bit       timed_out;

  or1k_decode_stage UUT (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic compare_outputs(input dec_exp_t e);
    check_val("opc_alu_o", 32'(e.opc_alu), 32'(opc_alu_o));
    check_val("opc_alu_secondary_o", 32'(e.opc_alu_sec), 32'(opc_alu_secondary_o));
    check_val("immediate_sel_o", 32'(e.imm_sel), 32'(immediate_sel_o));
    // Immediate value only means something when it is selected
    if (e.imm_sel) begin
      check_val("immediate_o", e.imm, immediate_o);
    end
    check_val("rfd_adr_o", 32'(e.rfd), 32'(rfd_adr_o));
    check_val("rfa_adr_o", 32'(e.rfa), 32'(rfa_adr_o));
    check_val("rfb_adr_o", 32'(e.rfb), 32'(rfb_adr_o));
    check_val("rf_wb_o", 32'(e.rf_wb), 32'(rf_wb_o));
    check_val("op_jbr_o", 32'(e.jbr), 32'(op_jbr_o));
    check_val("op_jr_o", 32'(e.jr), 32'(op_jr_o));
    check_val("op_jal_o", 32'(e.jal), 32'(op_jal_o));
    check_val("op_bf_o", 32'(e.bf), 32'(op_bf_o));
    check_val("op_bnf_o", 32'(e.bnf), 32'(op_bnf_o));
    check_val("op_alu_o", 32'(e.alu), 32'(op_alu_o));
    check_val("op_lsu_load_o", 32'(e.load), 32'(op_lsu_load_o));
    check_val("op_lsu_store_o", 32'(e.store), 32'(op_lsu_store_o));
    check_val("lsu_length_o", 32'(e.lsu_len), 32'(lsu_length_o));
    check_val("lsu_zext_o", 32'(e.zext), 32'(lsu_zext_o));
    check_val("op_mfspr_o", 32'(e.mfspr), 32'(op_mfspr_o));
    check_val("op_mtspr_o", 32'(e.mtspr), 32'(op_mtspr_o));
    check_val("op_rfe_o", 32'(e.rfe), 32'(op_rfe_o));
    check_val("op_setflag_o", 32'(e.setflag), 32'(op_setflag_o));
    check_val("op_add_o", 32'(e.add), 32'(op_add_o));
    check_val("op_mul_o", 32'(e.mul), 32'(op_mul_o));
    check_val("op_shift_o", 32'(e.shift), 32'(op_shift_o));
    check_val("op_movhi_o", 32'(e.movhi), 32'(op_movhi_o));
    check_val("op_msync_o", 32'(e.msync), 32'(op_msync_o));
    check_val("adder_do_sub_o", 32'(e.sub), 32'(adder_do_sub_o));
    check_val("except_illegal_o", 32'(e.illegal), 32'(except_illegal_o));
    check_val("except_syscall_o", 32'(e.syscall), 32'(except_syscall_o));
    check_val("except_trap_o", 32'(e.trap), 32'(except_trap_o));
  endtask

  // Checker runs on the falling edge where every signal is settled
  always @(negedge clk) begin
    if (arst_n_i) begin
      cyc++;
      if (valid_o) begin
        assert (exp_q.size() != 0) else begin
          $display("valid_o went high at %0t ns with no instruction outstanding", $time);
          errors++;
        end
        if (exp_q.size() != 0) begin
          due = due_q.pop_front();
          assert (due == cyc) else begin
            $display("Result at %0t ns came %0d cycles after its instruction instead of 2",
                     $time, cyc - due + 2);
            errors++;
          end
          compare_outputs(exp_q.pop_front());
          results++;
        end
      end else if (due_q.size() != 0) begin
        assert (due_q[0] > cyc) else begin
          $display("No result at %0t ns for an instruction accepted two cycles earlier", $time);
          errors++;
          void'(due_q.pop_front());
          void'(exp_q.pop_front());
        end
      end
      // Accepted on the next rising edge, result two edges later
      if (insn_valid_i) begin
        exp_q.push_back(model_decode(insn_i));
        due_q.push_back(cyc + 2);
        accepted++;
      end
    end
  end

  task automatic drive_insn(input logic [31:0] w);
    @(posedge clk);
    insn_valid_i <= 1'b1;
    insn_i       <= w;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      insn_valid_i <= 1'b0;
    end
  endtask

  task automatic wait_drain(input string what);
    int cycles;
    cycles = 0;
    while ((exp_q.size() != 0) && !timed_out) begin
      @(posedge clk);
      cycles++;
      if (cycles >= DRAIN_LIMIT) begin
        $display("Timeout in %s: %0d results still missing after %0d cycles",
                 what, exp_q.size(), cycles);
        timed_out = 1'b1;
      end
    end
  endtask

  function automatic logic [31:0] rand_legal();
    logic [31:0] w;
    w = $urandom;
    w[31:26] = LEGAL_OPCS[$urandom_range(0, 29)];
    if (w[31:26] == 6'h38) begin
      w[3:0] = ALU_OK[$urandom_range(0, 7)];
    end
    if ((w[31:26] == 6'h2e) || ((w[31:26] == 6'h38) && (w[3:0] == 4'h8))) begin
      w[7:6] = 2'($urandom_range(0, 2));
    end
    if (w[31:26] == 6'h08) begin
      w[25:21] = SYS_OK[$urandom_range(0, 2)];
    end
    return w;
  endfunction

  task automatic start_test();
    err_start = errors;
    acc_start = accepted;
    res_start = results;
  endtask

  task automatic end_test(input string name);
    idle(1);
    wait_drain(name);
    assert (results - res_start == accepted - acc_start) else begin
      $display("%s: %0d results for %0d accepted instructions",
               name, results - res_start, accepted - acc_start);
      errors++;
    end
    $display("%-22s %s, %0d instructions, %0d errors", name,
             (errors == err_start) ? "ok" : "FAILED", accepted - acc_start, errors - err_start);
  endtask

  initial begin
    void'($urandom(32'h9908_b5cf));
    arst_n_i     = 1'b0;
    insn_valid_i = 1'b0;
    insn_i       = '0;

    // 1: reset state
    start_test();
    repeat (16) begin
      @(negedge clk);
      assert ((valid_o === 1'b0) && (except_illegal_o === 1'b0) &&
              (except_syscall_o === 1'b0) && (except_trap_o === 1'b0)) else begin
        $display("Outputs not cleared during reset at %0t ns", $time);
        errors++;
      end
    end
    @(posedge clk);
    arst_n_i <= 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_val("valid_o", 32'h0, 32'(valid_o));
      check_val("except_illegal_o", 32'h0, 32'(except_illegal_o));
      check_val("except_syscall_o", 32'h0, 32'(except_syscall_o));
      check_val("except_trap_o", 32'h0, 32'(except_trap_o));
    end
    end_test("reset_state");

    // 2: legal instructions back to back
    if (!timed_out) begin
      start_test();
      repeat (300) drive_insn(rand_legal());
      end_test("legal_back_to_back");
    end

    // 3: immediate forms
    if (!timed_out) begin
      start_test();
      repeat (200) drive_insn({IMM_OPCS[$urandom_range(0, 12)], 26'($urandom)});
      end_test("immediate_forms");
    end

    // 4: random words and every SYSTRAPSYNC sub-code
    if (!timed_out) begin
      start_test();
      repeat (300) drive_insn($urandom);
      for (int i = 0; i < 5; i++) begin
        repeat (4) drive_insn({6'h08, SYS_ALL[i], 21'($urandom)});
      end
      end_test("illegal_and_exceptions");
    end

    // 5: random idle gaps between instructions
    if (!timed_out) begin
      start_test();
      repeat (200) begin
        drive_insn(rand_legal());
        idle($urandom_range(0, 3));
      end
      end_test("idle_gaps");
    end

    $display("Checks: %0d, errors: %0d, instructions: %0d, results: %0d",
             checks, errors, accepted, results);
    if ((errors == 0) && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
